// File: compile.f
src/mips_pkg.sv
src/alu_control.sv
src/control_unit.sv
src/register_file.sv
src/id_ex_stage.sv
src/decode_stage.sv
test/decode_stage_checker.sv
test/decode_stage_tb.sv

// File: run.sh
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f compile.f --top-module decode_stage_tb -o decode_sim \
	&& ./obj_dir/decode_sim +verilator+error+limit+1000 > sim.log 2>&1 \
	|| echo "sim failed" >> sim.log
cat sim.log
grep -q "sim failed" sim.log && exit 1 || exit 0

// File: src/alu_control.sv
`timescale 1ns/1ps

module alu_control (
	input  mips_pkg::aluop_t    aluop,
	input  mips_pkg::funct_t    funct,
	output mips_pkg::alu_code_t alu_code
);

	import mips_pkg::*;

	always_comb
	begin
		alu_code = ALU_ADD;  // Fallback for anything not listed
		case (aluop)
			AOP_RTYPE:
			begin
				case (funct)
					6'b000000: alu_code = ALU_SLL;
					6'b000010: alu_code = ALU_SRL;
					6'b000011: alu_code = ALU_SRA;
					6'b100000,
					6'b100001: alu_code = ALU_ADD;  // ADD, ADDU
					6'b100010,
					6'b100011: alu_code = ALU_SUB;  // SUB, SUBU
					6'b100100: alu_code = ALU_AND;
					6'b100101: alu_code = ALU_OR;
					6'b100110: alu_code = ALU_XOR;
					6'b100111: alu_code = ALU_NOR;
					6'b101010: alu_code = ALU_SLT;
					default:   alu_code = ALU_ADD;
				endcase
			end
			AOP_ADD: alu_code = ALU_ADD;
			AOP_AND: alu_code = ALU_AND;
			AOP_OR:  alu_code = ALU_OR;
			AOP_XOR: alu_code = ALU_XOR;
			AOP_SUB: alu_code = ALU_SUB;
			AOP_SLT: alu_code = ALU_SLT;
			AOP_LUI: alu_code = ALU_LUI;
			default: alu_code = ALU_ADD;
		endcase
	end

endmodule

// File: src/control_unit.sv
`timescale 1ns/1ps

module control_unit (
	input  mips_pkg::opcode_t      opcode,
	input  mips_pkg::funct_t       funct,
	output mips_pkg::ctrl_bundle_t ctrl,
	output mips_pkg::imm_kind_t    imm_kind
);

	import mips_pkg::*;

	logic [4:0]      ex_flags;  // reg_dst, alu_src1, alu_src2, jump, jump_reg
	memory_ctrl_t    mem_ctrl;  // branch, mem_read, mem_write
	writeback_ctrl_t wb_ctrl;   // reg_write, mem_to_reg
	aluop_t          aluop;
	alu_code_t       alu_code;

	alu_control u_alu_control (
		.aluop    (aluop),
		.funct    (funct),
		.alu_code (alu_code)
	);

	//////////////////////////////////////////////////////////////////////
	// Main opcode decode
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		// Undefined opcodes end up here, a bubble
		ex_flags = 5'b00000;
		mem_ctrl = 3'b000;
		wb_ctrl  = 2'b00;
		aluop    = AOP_ADD;
		imm_kind = IMM_SIGN;

		case (opcode)
			OP_RTYPE:
			begin
				aluop = AOP_RTYPE;
				case (funct)
					6'b000000, 6'b000010, 6'b000011:
					begin
						ex_flags = 5'b11000;  // Shift by shamt
						wb_ctrl  = 2'b10;
					end
					6'b001000:
					begin
						ex_flags = 5'b00001;  // JR writes nothing
					end
					6'b001001:
					begin
						ex_flags = 5'b10001;  // JALR links into rd
						wb_ctrl  = 2'b10;
					end
					default:
					begin
						ex_flags = 5'b10000;
						wb_ctrl  = 2'b10;
					end
				endcase
			end
			OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_LWU:
			begin
				ex_flags = 5'b00100;
				mem_ctrl = 3'b010;
				wb_ctrl  = 2'b11;
			end
			OP_SB, OP_SH, OP_SW:
			begin
				ex_flags = 5'b00100;
				mem_ctrl = 3'b001;
			end
			OP_ADDI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI, OP_SLTI:
			begin
				// Immediate ALU ops share flags, only class and extension differ
				ex_flags = 5'b00100;
				wb_ctrl  = 2'b10;
				case (opcode)
					OP_ANDI: aluop = AOP_AND;
					OP_ORI:  aluop = AOP_OR;
					OP_XORI: aluop = AOP_XOR;
					OP_LUI:  aluop = AOP_LUI;
					OP_SLTI: aluop = AOP_SLT;
					default: aluop = AOP_ADD;
				endcase
				if (opcode == OP_ANDI || opcode == OP_ORI || opcode == OP_XORI)
					imm_kind = IMM_ZERO;
				else if (opcode == OP_LUI)
					imm_kind = IMM_UPPER;
			end
			OP_BEQ, OP_BNE:
			begin
				mem_ctrl = 3'b100;
				aluop    = AOP_SUB;  // Compare by subtraction
			end
			OP_J:
			begin
				ex_flags = 5'b00010;
				mem_ctrl = 3'b100;
			end
			OP_JAL:
			begin
				ex_flags = 5'b00010;
				mem_ctrl = 3'b100;
				wb_ctrl  = 2'b10;  // Link register
			end
			default: ;
		endcase
	end

	// ALU code goes into the low nibble of the execute group
	assign ctrl = {ex_flags, alu_code, mem_ctrl, wb_ctrl};

endmodule

// File: src/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
	input  logic                clk,
	input  logic                reset,
	input  mips_pkg::word_t     instr,
	input  logic                wb_write,
	input  mips_pkg::reg_addr_t wb_addr,
	input  mips_pkg::word_t     wb_data,
	output mips_pkg::id_ex_t    id_ex
);

	import mips_pkg::*;

	opcode_t      opcode;
	funct_t       funct;
	reg_addr_t    rs;
	reg_addr_t    rt;
	ctrl_bundle_t ctrl;
	imm_kind_t    imm_kind;
	word_t        rs_data;
	word_t        rt_data;

	// Instruction fields
	assign opcode = instr[31:26];
	assign funct  = instr[5:0];
	assign rs     = instr[25:21];
	assign rt     = instr[20:16];

	control_unit u_control_unit (
		.opcode   (opcode),
		.funct    (funct),
		.ctrl     (ctrl),
		.imm_kind (imm_kind)
	);

	register_file u_register_file (
		.clk        (clk),
		.reset      (reset),
		.rs         (rs),
		.rt         (rt),
		.write      (wb_write),
		.write_addr (wb_addr),
		.write_data (wb_data),
		.rs_data    (rs_data),
		.rt_data    (rt_data)
	);

	id_ex_stage u_id_ex_stage (
		.clk      (clk),
		.reset    (reset),
		.instr    (instr),
		.ctrl     (ctrl),
		.imm_kind (imm_kind),
		.rs_data  (rs_data),
		.rt_data  (rt_data),
		.id_ex    (id_ex)
	);

endmodule

// File: src/id_ex_stage.sv
`timescale 1ns/1ps

module id_ex_stage (
	input  logic                   clk,
	input  logic                   reset,
	input  mips_pkg::word_t        instr,
	input  mips_pkg::ctrl_bundle_t ctrl,
	input  mips_pkg::imm_kind_t    imm_kind,
	input  mips_pkg::word_t        rs_data,
	input  mips_pkg::word_t        rt_data,
	output mips_pkg::id_ex_t       id_ex
);

	import mips_pkg::*;

	logic [15:0] imm16;
	word_t       imm_ext;
	id_ex_t      id_ex_next;

	assign imm16 = instr[15:0];

	// Immediate extension
	always_comb
	begin
		case (imm_kind)
			IMM_ZERO:  imm_ext = {16'h0000, imm16};
			IMM_UPPER: imm_ext = {imm16, 16'h0000};  // LUI
			default:   imm_ext = {{16{imm16[15]}}, imm16};
		endcase
	end

	always_comb
	begin
		id_ex_next.ctrl    = ctrl;
		id_ex_next.rs_data = rs_data;
		id_ex_next.rt_data = rt_data;
		id_ex_next.imm     = imm_ext;
		id_ex_next.shamt   = instr[10:6];
		id_ex_next.rs      = instr[25:21];
		id_ex_next.rt      = instr[20:16];
		id_ex_next.rd      = instr[15:11];
	end

	// Cleared register is a bubble, all controls off
	always_ff @(posedge clk)
	begin
		if (reset)
			id_ex <= '0;
		else
			id_ex <= id_ex_next;
	end

endmodule

// File: src/mips_pkg.sv
package mips_pkg;

	//////////////////////////////////////////////////////////////////////
	// Widths and field types
	//////////////////////////////////////////////////////////////////////

	localparam int WORD_W     = 32;
	localparam int REG_ADDR_W = 5;
	localparam int NUM_REGS   = 32;

	typedef logic [WORD_W-1:0]     word_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;
	typedef logic [5:0]            opcode_t;
	typedef logic [5:0]            funct_t;
	typedef logic [4:0]            shamt_t;
	typedef logic [3:0]            alu_code_t;
	typedef logic [2:0]            aluop_t;

	// ALU operation codes seen by the execute stage
	localparam alu_code_t ALU_AND = 4'b0000;
	localparam alu_code_t ALU_OR  = 4'b0001;
	localparam alu_code_t ALU_ADD = 4'b0010;
	localparam alu_code_t ALU_XOR = 4'b0011;
	localparam alu_code_t ALU_SUB = 4'b0110;
	localparam alu_code_t ALU_SLT = 4'b0111;
	localparam alu_code_t ALU_SLL = 4'b1000;
	localparam alu_code_t ALU_SRL = 4'b1001;
	localparam alu_code_t ALU_SRA = 4'b1010;
	localparam alu_code_t ALU_NOR = 4'b1100;
	localparam alu_code_t ALU_LUI = 4'b1101;

	// Operation classes from the main decoder
	localparam aluop_t AOP_RTYPE = 3'b000;  // Look at funct
	localparam aluop_t AOP_ADD   = 3'b001;
	localparam aluop_t AOP_AND   = 3'b010;
	localparam aluop_t AOP_OR    = 3'b011;
	localparam aluop_t AOP_XOR   = 3'b100;
	localparam aluop_t AOP_SUB   = 3'b101;
	localparam aluop_t AOP_SLT   = 3'b110;
	localparam aluop_t AOP_LUI   = 3'b111;

	// Opcodes
	localparam opcode_t OP_RTYPE = 6'b000000;
	localparam opcode_t OP_J     = 6'b000010;
	localparam opcode_t OP_JAL   = 6'b000011;
	localparam opcode_t OP_BEQ   = 6'b000100;
	localparam opcode_t OP_BNE   = 6'b000101;
	localparam opcode_t OP_ADDI  = 6'b001000;
	localparam opcode_t OP_SLTI  = 6'b001010;
	localparam opcode_t OP_ANDI  = 6'b001100;
	localparam opcode_t OP_ORI   = 6'b001101;
	localparam opcode_t OP_XORI  = 6'b001110;
	localparam opcode_t OP_LUI   = 6'b001111;
	localparam opcode_t OP_LB    = 6'b100000;
	localparam opcode_t OP_LH    = 6'b100001;
	localparam opcode_t OP_LW    = 6'b100011;
	localparam opcode_t OP_LBU   = 6'b100100;
	localparam opcode_t OP_LHU   = 6'b100101;
	localparam opcode_t OP_LWU   = 6'b100111;
	localparam opcode_t OP_SB    = 6'b101000;
	localparam opcode_t OP_SH    = 6'b101001;
	localparam opcode_t OP_SW    = 6'b101011;

	typedef enum logic [1:0] {IMM_SIGN, IMM_ZERO, IMM_UPPER} imm_kind_t;

	//////////////////////////////////////////////////////////////////////
	// Control bundles and the ID/EX register
	//////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic      reg_dst;
		logic      alu_src1;  // Shamt as first operand
		logic      alu_src2;  // Immediate as second operand
		logic      jump;
		logic      jump_reg;
		alu_code_t alu_code;
	} execute_ctrl_t;

	typedef struct packed {
		logic branch;
		logic mem_read;
		logic mem_write;
	} memory_ctrl_t;

	typedef struct packed {
		logic reg_write;
		logic mem_to_reg;
	} writeback_ctrl_t;

	typedef struct packed {
		execute_ctrl_t   ex;
		memory_ctrl_t    mem;
		writeback_ctrl_t wb;
	} ctrl_bundle_t;

	typedef struct packed {
		ctrl_bundle_t ctrl;
		word_t        rs_data;
		word_t        rt_data;
		word_t        imm;
		shamt_t       shamt;
		reg_addr_t    rs;
		reg_addr_t    rt;
		reg_addr_t    rd;
	} id_ex_t;

endpackage

// File: src/register_file.sv
`timescale 1ns/1ps

module register_file (
	input  logic                clk,
	input  logic                reset,
	input  mips_pkg::reg_addr_t rs,
	input  mips_pkg::reg_addr_t rt,
	input  logic                write,
	input  mips_pkg::reg_addr_t write_addr,
	input  mips_pkg::word_t     write_data,
	output mips_pkg::word_t     rs_data,
	output mips_pkg::word_t     rt_data
);

	import mips_pkg::*;

	word_t regs [NUM_REGS];

	// Write port from the write-back stage
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
		end
		else if (write && write_addr != '0)
		begin
			regs[write_addr] <= write_data;
		end
	end

	// No bypass, a same-cycle read sees the old value
	assign rs_data = (rs == '0) ? '0 : regs[rs];
	assign rt_data = (rt == '0) ? '0 : regs[rt];

endmodule

// File: test/decode_stage_checker.sv
`timescale 1ns/1ps

module decode_stage_checker (
	input logic             clk,
	input logic             reset,
	input mips_pkg::id_ex_t id_ex
);

	// Register holds a bubble after any reset cycle
	reset_clears: assert property (@(posedge clk) reset |=> id_ex == '0)
		else $error("id_ex not all zero after reset");

	mem_exclusive: assert property (@(posedge clk) disable iff (reset)
		!(id_ex.ctrl.mem.mem_read && id_ex.ctrl.mem.mem_write))
		else $error("mem_read and mem_write set together");

	jump_exclusive: assert property (@(posedge clk) disable iff (reset)
		!(id_ex.ctrl.ex.jump && id_ex.ctrl.ex.jump_reg))  // J and JR never overlap
		else $error("jump and jump_reg set together");

endmodule

bind decode_stage decode_stage_checker u_checker (
	.clk   (clk),
	.reset (reset),
	.id_ex (id_ex)
);

// File: test/decode_stage_tb.sv
`timescale 1ns/1ps

module decode_stage_tb;

	import mips_pkg::*;

	localparam int RESET_CYCLES = 3;
	localparam int N_RTYPE      = 300;
	localparam int N_IMM        = 300;
	localparam int N_MEMCTL     = 300;
	localparam int N_REGFILE    = 400;
	localparam int N_UNDEF      = 200;
	localparam int TIMEOUT_CYCLES = RESET_CYCLES + 1 + N_RTYPE + N_IMM + N_MEMCTL
		+ N_REGFILE + N_UNDEF + 200;

	localparam funct_t LISTED_FUNCTS [14] = '{6'h00, 6'h02, 6'h03, 6'h08, 6'h09, 6'h20,
		6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27, 6'h2a};
	localparam opcode_t IMM_OPS [6] = '{OP_ADDI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI, OP_SLTI};
	localparam opcode_t MEMCTL_OPS [13] = '{OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_LWU,
		OP_SB, OP_SH, OP_SW, OP_BEQ, OP_BNE, OP_J, OP_JAL};

	logic      clk = 1'b0;
	logic      reset;
	word_t     instr;
	logic      wb_write;
	reg_addr_t wb_addr;
	word_t     wb_data;
	id_ex_t    id_ex;

	word_t       model_regs [NUM_REGS];  // Reference register contents
	logic [31:0] lcg_state;
	int          cycles = 0;
	int          test_errors = 0;
	int          errors = 0;
	int          tests_run = 0;
	int          tests_failed = 0;

	decode_stage DUT (
		.clk      (clk),
		.reset    (reset),
		.instr    (instr),
		.wb_write (wb_write),
		.wb_addr  (wb_addr),
		.wb_data  (wb_data),
		.id_ex    (id_ex)
	);

	always #4 clk = ~clk;

	always @(posedge clk)
	begin
		cycles++;
		if (cycles > TIMEOUT_CYCLES)
		begin
			$display("Timeout: run still going after %0d cycles", TIMEOUT_CYCLES);
			$display("sim failed");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Random numbers and instruction picks
	//////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic int unsigned rand_below(int unsigned n);
		return (lcg_next() >> 8) % n;  // Low LCG bits are weak
	endfunction

	function automatic word_t rtype_instr();
		word_t w;
		w = lcg_next();
		w[31:26] = OP_RTYPE;
		if (rand_below(4) != 0)
			w[5:0] = LISTED_FUNCTS[rand_below(14)];
		return w;
	endfunction

	function automatic logic is_defined(opcode_t op);
		logic hit;
		hit = (op == OP_RTYPE);
		for (int i = 0; i < 6; i++)
			hit = hit | (op == IMM_OPS[i]);
		for (int i = 0; i < 13; i++)
			hit = hit | (op == MEMCTL_OPS[i]);
		return hit;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////////////////////////

	function automatic alu_code_t funct_alu(funct_t f);
		case (f)
			6'h00: return ALU_SLL;
			6'h02: return ALU_SRL;
			6'h03: return ALU_SRA;
			6'h22, 6'h23: return ALU_SUB;
			6'h24: return ALU_AND;
			6'h25: return ALU_OR;
			6'h26: return ALU_XOR;
			6'h27: return ALU_NOR;
			6'h2a: return ALU_SLT;
			default: return ALU_ADD;
		endcase
	endfunction

	function automatic ctrl_bundle_t expected_ctrl(word_t ins);
		ctrl_bundle_t c;
		funct_t       f;
		c = '0;
		f = ins[5:0];
		c.ex.alu_code = ALU_ADD;
		case (ins[31:26])
			OP_RTYPE:
			begin
				c.ex.alu_code  = funct_alu(f);
				c.ex.reg_dst   = (f != 6'h08);  // All but JR write rd
				c.ex.alu_src1  = (f == 6'h00 || f == 6'h02 || f == 6'h03);
				c.ex.jump_reg  = (f == 6'h08 || f == 6'h09);
				c.wb.reg_write = (f != 6'h08);
			end
			OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_LWU:
			begin
				c.ex.alu_src2  = 1'b1;
				c.mem.mem_read = 1'b1;
				c.wb           = 2'b11;
			end
			OP_SB, OP_SH, OP_SW:
			begin
				c.ex.alu_src2   = 1'b1;
				c.mem.mem_write = 1'b1;
			end
			OP_ADDI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI, OP_SLTI:
			begin
				c.ex.alu_src2  = 1'b1;
				c.wb.reg_write = 1'b1;
				case (ins[31:26])
					OP_ANDI: c.ex.alu_code = ALU_AND;
					OP_ORI:  c.ex.alu_code = ALU_OR;
					OP_XORI: c.ex.alu_code = ALU_XOR;
					OP_LUI:  c.ex.alu_code = ALU_LUI;
					OP_SLTI: c.ex.alu_code = ALU_SLT;
					default: c.ex.alu_code = ALU_ADD;
				endcase
			end
			OP_BEQ, OP_BNE:
			begin
				c.mem.branch  = 1'b1;
				c.ex.alu_code = ALU_SUB;
			end
			OP_J, OP_JAL:
			begin
				c.ex.jump      = 1'b1;
				c.mem.branch   = 1'b1;
				c.wb.reg_write = (ins[31:26] == OP_JAL);
			end
			default: ;  // Bubble
		endcase
		return c;
	endfunction

	function automatic word_t expected_imm(word_t ins);
		case (ins[31:26])
			OP_ANDI, OP_ORI, OP_XORI: return {16'h0000, ins[15:0]};
			OP_LUI: return {ins[15:0], 16'h0000};
			default: return {{16{ins[15]}}, ins[15:0]};
		endcase
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Compare tasks and stimulus
	//////////////////////////////////////////////////////////////////////

	task automatic check_ctrl(string name, ctrl_bundle_t got, ctrl_bundle_t exp);
		if (got !== exp)
		begin
			$display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			test_errors++;
		end
	endtask

	task automatic check_word(string name, word_t got, word_t exp);
		if (got !== exp)
		begin
			$display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			test_errors++;
		end
	endtask

	task automatic check_shamt(string name, shamt_t got, shamt_t exp);
		if (got !== exp)
		begin
			$display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			test_errors++;
		end
	endtask

	task automatic check_addr(string name, reg_addr_t got, reg_addr_t exp);
		if (got !== exp)
		begin
			$display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			test_errors++;
		end
	endtask

	task automatic check_id_ex(id_ex_t exp);
		check_ctrl("id_ex.ctrl", id_ex.ctrl, exp.ctrl);
		check_word("id_ex.rs_data", id_ex.rs_data, exp.rs_data);
		check_word("id_ex.rt_data", id_ex.rt_data, exp.rt_data);
		check_word("id_ex.imm", id_ex.imm, exp.imm);
		check_shamt("id_ex.shamt", id_ex.shamt, exp.shamt);
		check_addr("id_ex.rs", id_ex.rs, exp.rs);
		check_addr("id_ex.rt", id_ex.rt, exp.rt);
		check_addr("id_ex.rd", id_ex.rd, exp.rd);
	endtask

	// Called at a falling edge, returns at the next one after checking
	task automatic run_cycle(word_t ins, logic wr, reg_addr_t wa, word_t wd);
		id_ex_t exp;
		instr    = ins;
		wb_write = wr;
		wb_addr  = wa;
		wb_data  = wd;
		exp.ctrl    = expected_ctrl(ins);
		exp.rs_data = model_regs[ins[25:21]];  // Old values, no bypass
		exp.rt_data = model_regs[ins[20:16]];
		exp.imm     = expected_imm(ins);
		exp.shamt   = ins[10:6];
		exp.rs      = ins[25:21];
		exp.rt      = ins[20:16];
		exp.rd      = ins[15:11];
		@(posedge clk);
		if (wr && wa != 5'd0)
			model_regs[wa] = wd;
		@(negedge clk);
		check_id_ex(exp);
	endtask

	task automatic close_test(string name, int n);
		tests_run++;
		if (test_errors == 0)
			$display("ok      %-16s %0d cycles", name, n);
		else
		begin
			$display("FAILED  %-16s %0d errors", name, test_errors);
			tests_failed++;
		end
		errors += test_errors;
		test_errors = 0;
	endtask

	initial
	begin
		word_t       w;
		logic [31:0] r;
		lcg_state = 32'd40667;
		reset     = 1'b1;
		instr     = '0;
		wb_write  = 1'b0;
		wb_addr   = '0;
		wb_data   = '0;
		for (int i = 0; i < NUM_REGS; i++)
			model_regs[i] = '0;

		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		check_id_ex('0);
		run_cycle(rtype_instr(), 1'b0, '0, '0);  // Cleared registers read zero
		close_test("reset", 1);

		repeat (N_RTYPE) run_cycle(rtype_instr(), 1'b0, '0, '0);
		close_test("rtype", N_RTYPE);

		for (int i = 0; i < N_IMM; i++)
		begin
			w = lcg_next();
			w[31:26] = IMM_OPS[rand_below(6)];
			run_cycle(w, 1'b0, '0, '0);
		end
		close_test("immediate_alu", N_IMM);

		for (int i = 0; i < N_MEMCTL; i++)
		begin
			w = lcg_next();
			w[31:26] = MEMCTL_OPS[rand_below(13)];
			run_cycle(w, 1'b0, '0, '0);
		end
		close_test("mem_branch_jump", N_MEMCTL);

		for (int i = 0; i < N_REGFILE; i++)
		begin
			r = lcg_next();
			// Mostly writes, register 0 targeted now and then
			run_cycle(rtype_instr(), r[0] | r[1], (r[4:2] == 3'd0) ? 5'd0 : r[12:8], lcg_next());
		end
		close_test("register_file", N_REGFILE);

		for (int i = 0; i < N_UNDEF; i++)
		begin
			w = lcg_next();
			while (is_defined(w[31:26]))
				w = lcg_next();
			run_cycle(w, 1'b0, '0, '0);
		end
		close_test("undefined_opcode", N_UNDEF);

		$display("Tests run %0d, failed %0d, total errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule
